// File: flist.f
+incdir+.
uart_pkg.sv
frame_pkg.sv
uart_tx.sv
byte_fifo.sv
frame_tx_ctrl.sv
uart_rx.sv
frame_rx_ctrl.sv
uart_frame_top.sv
uart_frame_chk.sv
tb_uart_frame.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_uart_frame
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := sim failed
PASS_MSG  := sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "Simulation stopped early"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: tb_uart_frame.sv
// ---------------------------------------------------------------------------
// Testbench for the UART string link. Sends random frames in loopback and
// hand-built byte streams from a serial driver, checking each rx_done.
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "uart_frame_macros.svh"

module tb_uart_frame import frame_pkg::*; ();

	localparam int CPB         = `UF_CLKS_PER_BIT;
	localparam int BYTE_CLKS   = 10 * CPB;
	localparam int FRAME_LIMIT = 20 * BYTE_CLKS + 200;
	localparam int WATCHDOG_NS = 30 * 20 * BYTE_CLKS * 8 + 100000;

	logic        sys_clk;
	logic        sys_rst_n;
	frame_str_t  tx_string;
	frame_len_t  tx_length;
	logic        tx_req;
	logic        loopback;
	logic        drv_line;
	logic        uart_rx_port;
	logic        tx_busy;
	logic        tx_done;
	logic        rx_busy;
	logic        rx_done;
	logic        uart_tx_port;
	frame_str_t  rx_string;
	frame_len_t  rx_length;
	// Scoreboard.
	frame_str_t  exp_str;
	frame_len_t  exp_len;
	int          tx_done_cnt;
	int          rx_done_cnt;
	int          tx_target;
	int          rx_target;
	logic [16:0] lfsr;

	assign uart_rx_port = loopback ? uart_tx_port : drv_line;

	uart_frame_top i_uart_frame_top (
		.sys_clk, .sys_rst_n, .tx_string, .tx_length, .tx_req, .uart_rx_port,
		.tx_busy, .tx_done, .rx_string, .rx_length, .rx_busy, .rx_done, .uart_tx_port
	);

	initial begin
		sys_clk = 1'b0;
		forever #4 sys_clk = ~sys_clk;
	end

	// Taps 17 and 14, maximal length.
	function automatic logic lfsr_step();
		logic fb;
		fb   = lfsr[16] ^ lfsr[13];
		lfsr = {lfsr[15:0], fb};
		return fb;
	endfunction

	function automatic logic [7:0] rand_bits(input int n);
		logic [7:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
			v = {v[6:0], lfsr_step()};
		return v;
	endfunction

	// Printable range 0x30 to 0x6f, never the delimiter.
	function automatic logic [7:0] rand_char();
		return 8'h30 + rand_bits(6);
	endfunction

	function automatic frame_str_t pack_text(input string s);
		frame_str_t r;
		r = '0;
		for (int i = 0; i < s.len(); i++)
			r[8*i +: 8] = s[i];
		return r;
	endfunction

	task automatic tick(input int n);
		repeat (n) @(posedge sys_clk);
		#1;
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("sim failed");
		$fatal(1, "run stopped on first error");
	endtask

	task automatic report_mismatch(input string name, input logic [127:0] got,
			input logic [127:0] want);
		abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, want));
	endtask

	task automatic wait_counts();
		int n;
		n = 0;
		while ((tx_done_cnt < tx_target || rx_done_cnt < rx_target) && n < FRAME_LIMIT) begin
			tick(1);
			n++;
		end
		if (tx_done_cnt < tx_target || rx_done_cnt < rx_target)
			abort_run("timed out waiting for tx_done or rx_done");
	endtask

	// Unused string slots get garbage that must not come back.
	task automatic send_frame(input frame_len_t len, input logic extra_req);
		frame_str_t drive;
		frame_str_t want;
		logic [7:0] c;
		for (int k = 0; k < `UF_MAX_CHARS; k++) begin
			c                = rand_char();
			drive[8*k +: 8] = c;
			want[8*k +: 8]  = (k < len) ? c : 8'h00;
		end
		assert (!tx_busy) else abort_run("transmitter still busy when a request was due");
		exp_str   = want;
		exp_len   = len;
		tx_string = drive;
		tx_length = len;
		tx_req    = 1'b1;
		tick(1);
		tx_req = 1'b0;
		tx_target++;
		rx_target++;
		if (extra_req) begin
			tick(40);
			assert (tx_busy) else abort_run("transmitter idle during a frame");
			tx_length = 8'd5;
			tx_req    = 1'b1;
			tick(1);
			tx_req = 1'b0;
		end
		wait_counts();
	endtask

	task automatic uart_send_text(input string s);
		logic [9:0] bits;
		for (int i = 0; i < s.len(); i++) begin
			bits = {1'b1, s[i], 1'b0};
			for (int b = 0; b < 10; b++) begin
				drv_line = bits[b];
				tick(CPB);
			end
		end
	endtask

	always @(negedge sys_clk) begin
		if (sys_rst_n && tx_done)
			tx_done_cnt++;
		if (sys_rst_n && rx_done) begin
			rx_done_cnt++;
			assert (rx_length == exp_len)
				else report_mismatch("rx_length", 128'(rx_length), 128'(exp_len));
			assert (rx_string == exp_str)
				else report_mismatch("rx_string", rx_string, exp_str);
		end
	end

	initial begin
		#(WATCHDOG_NS);
		abort_run("watchdog expired before the tests finished");
	end

	initial begin
		lfsr        = 17'd80336;
		sys_rst_n   = 1'b0;
		tx_string   = '0;
		tx_length   = '0;
		tx_req      = 1'b0;
		loopback    = 1'b1;
		drv_line    = 1'b1;
		exp_str     = '0;
		exp_len     = '0;
		tx_done_cnt = 0;
		rx_done_cnt = 0;
		tx_target   = 0;
		rx_target   = 0;
		tick(4);
		assert (!tx_busy && !tx_done && !rx_busy && !rx_done && uart_tx_port)
			else abort_run("control outputs wrong during reset");
		assert (rx_string == '0)
			else report_mismatch("rx_string", rx_string, '0);
		assert (rx_length == '0)
			else report_mismatch("rx_length", 128'(rx_length), '0);
		sys_rst_n = 1'b1;
		tick(2);

		// Random lengths 1 to 16 in loopback.
		for (int i = 0; i < 12; i++)
			send_frame(frame_len_t'(rand_bits(4)) + 8'd1, 1'b0);
		send_frame(8'd0, 1'b0);
		// A request while busy must not start a frame.
		send_frame(8'd6, 1'b1);
		tick(2 * BYTE_CLKS);
		assert (tx_done_cnt == tx_target && rx_done_cnt == rx_target && !tx_busy)
			else abort_run("an extra frame followed a request made while busy");
		// Back to back full frames, FIFO runs full.
		for (int i = 0; i < 4; i++)
			send_frame(8'd16, 1'b0);

		loopback = 1'b0;
		exp_str  = pack_text("ab");
		exp_len  = 8'd2;
		rx_target++;
		uart_send_text("&x&&ab");
		assert (rx_busy) else abort_run("parser idle in the middle of a frame");
		uart_send_text("&&");
		wait_counts();
		assert (!rx_busy) else abort_run("parser still busy after a complete frame");
		// Overlong frame is dropped and the last result stays.
		uart_send_text("&&ABCDEFGHIJKLMNOPQ&&");
		tick(4 * CPB);
		assert (rx_done_cnt == rx_target)
			else abort_run("an overlong frame raised rx_done");
		assert (rx_string == exp_str)
			else report_mismatch("rx_string", rx_string, exp_str);
		assert (rx_length == exp_len)
			else report_mismatch("rx_length", 128'(rx_length), 128'(exp_len));
		exp_str = pack_text("xyz");
		exp_len = 8'd3;
		rx_target++;
		uart_send_text("&&xyz&&");
		wait_counts();

		tick(10);
		if (tx_done_cnt == tx_target && rx_done_cnt == rx_target) begin
			$display("sim passed");
			$finish;
		end else begin
			abort_run("done counts differ from the number of frames sent");
		end
	end

endmodule

`default_nettype wire

// File: uart_frame_chk.sv
// ---------------------------------------------------------------------------
// Protocol assertions for the UART string link, bound into the top level.
// Covers the transmit done and busy relation and the receive done pulse.
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "uart_frame_macros.svh"

module uart_frame_chk import frame_pkg::*; (
	input wire             sys_clk,
	input wire             sys_rst_n,
	input wire             tx_busy,
	input wire             tx_done,
	input wire             uart_tx_port,
	input wire frame_len_t rx_length,
	input wire             rx_done
);

	// Busy drops in the same cycle as done.
	tx_done_after_busy: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		tx_done |-> ($past(tx_busy) && !tx_busy))
		else $error("tx_done seen without a busy period ending with it");

	// Idle line outside a frame.
	tx_line_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!tx_busy |-> uart_tx_port)
		else $error("transmit line low while the transmitter is idle");

	rx_length_limit: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |-> (rx_length <= frame_len_t'(`UF_MAX_CHARS)))
		else $error("published receive length above the frame limit");

	rx_done_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		rx_done |=> !rx_done)
		else $error("rx_done held for more than one cycle");

endmodule

bind uart_frame_top uart_frame_chk i_uart_frame_chk (
	.sys_clk      (sys_clk),
	.sys_rst_n    (sys_rst_n),
	.tx_busy      (tx_busy),
	.tx_done      (tx_done),
	.uart_tx_port (uart_tx_port),
	.rx_length    (rx_length),
	.rx_done      (rx_done)
);

`default_nettype wire

// File: uart_frame_top.sv
// ---------------------------------------------------------------------------
// Top level of the UART string link. The transmit path is producer, FIFO and
// serializer; the receive path is deserializer and frame parser.
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

module uart_frame_top import uart_pkg::*, frame_pkg::*; (
	input  wire             sys_clk,
	input  wire             sys_rst_n,
	input  wire frame_str_t tx_string,
	input  wire frame_len_t tx_length,
	input  wire             tx_req,
	input  wire             uart_rx_port,
	output logic            tx_busy,
	output logic            tx_done,
	output frame_str_t      rx_string,
	output frame_len_t      rx_length,
	output logic            rx_busy,
	output logic            rx_done,
	output logic            uart_tx_port
);

	logic          push;
	uart_byte_t    push_data;
	logic          pop;
	uart_byte_t    pop_data;
	logic          full;
	logic          empty;
	logic          byte_sent;
	rx_beat_t      rx_beat;
	frame_result_t frame;

	assign rx_string = frame.str;
	assign rx_length = frame.len;

	frame_tx_ctrl i_frame_tx_ctrl (
		.sys_clk, .sys_rst_n, .tx_string, .tx_length, .tx_req,
		.full, .byte_sent, .push, .push_data, .tx_busy, .tx_done
	);

	byte_fifo i_byte_fifo (
		.sys_clk, .sys_rst_n, .push, .push_data, .pop, .pop_data, .full, .empty
	);

	uart_tx i_uart_tx (
		.sys_clk, .sys_rst_n, .empty, .pop_data, .pop, .byte_sent, .uart_tx_port
	);

	uart_rx i_uart_rx (
		.sys_clk, .sys_rst_n, .uart_rx_port, .rx_beat
	);

	frame_rx_ctrl i_frame_rx_ctrl (
		.sys_clk, .sys_rst_n, .rx_beat, .frame, .busy(rx_busy), .done(rx_done)
	);

endmodule

`default_nettype wire

// File: frame_rx_ctrl.sv
// ---------------------------------------------------------------------------
// Frame parser. Looks for "&&", up to 16 characters and "&&" in the byte
// beats, then publishes string and length with a one-cycle done.
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "uart_frame_macros.svh"

module frame_rx_ctrl import uart_pkg::*, frame_pkg::*; (
	input  wire           sys_clk,
	input  wire           sys_rst_n,
	input  wire rx_beat_t rx_beat,
	output frame_result_t frame,
	output logic          busy,
	output logic          done
);

	localparam frame_len_t MAX_LEN = frame_len_t'(`UF_MAX_CHARS);

	rx_state_e  state;
	frame_str_t work_str;
	frame_len_t work_len;
	// Set when a frame runs past 16 characters.
	logic       overflow;
	logic       is_delim;

	assign is_delim = (rx_beat.data == `UF_DELIM);
	assign busy     = (state != RX_IDLE);

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= RX_IDLE;
			work_str <= '0;
			work_len <= '0;
			overflow <= 1'b0;
			frame    <= '0;
			done     <= 1'b0;
		end else begin
			done <= 1'b0;
			if (rx_beat.vld) begin
				case (state)
					RX_IDLE:
						if (is_delim)
							state <= RX_OPEN1;
					RX_OPEN1:
						if (is_delim) begin
							work_str <= '0;
							work_len <= '0;
							overflow <= 1'b0;
							state    <= RX_BODY;
						end else begin
							state <= RX_IDLE;
						end
					RX_BODY:
						if (is_delim) begin
							state <= RX_CLOSE1;
						end else if (work_len == MAX_LEN) begin
							// Too long, swallow the rest up to the closing pair.
							overflow <= 1'b1;
						end else begin
							work_str[8*work_len +: 8] <= rx_beat.data;
							work_len                  <= work_len + 8'd1;
						end
					RX_CLOSE1: begin
						// Overlong frames end here without being published.
						if (is_delim && !overflow) begin
							frame <= '{str: work_str, len: work_len};
							done  <= 1'b1;
						end
						state <= RX_IDLE;
					end
					default:
						state <= RX_IDLE;
				endcase
			end
		end
	end

endmodule

`default_nettype wire

// File: uart_rx.sv
// ---------------------------------------------------------------------------
// Deserializer. Synchronizes the line, finds the start edge, samples each
// bit at its centre and emits a beat at mid stop bit if the stop is high.
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "uart_frame_macros.svh"

module uart_rx import uart_pkg::*; (
	input  wire       sys_clk,
	input  wire       sys_rst_n,
	input  wire       uart_rx_port,
	output rx_beat_t  rx_beat
);

	localparam baud_cnt_t  BAUD_LAST = baud_cnt_t'(`UF_CLKS_PER_BIT - 1);
	localparam baud_cnt_t  BAUD_MID  = baud_cnt_t'(`UF_CLKS_PER_BIT / 2 - 1);
	localparam logic [3:0] STOP_BIT  = 4'd9;

	logic       rx_meta;
	logic       rx_sync;
	logic       rx_prev;
	logic       active;
	logic [3:0] bit_idx;
	baud_cnt_t  baud_cnt;
	uart_byte_t shreg;
	logic       vld_q;
	uart_byte_t data_q;

	assign rx_beat = '{vld: vld_q, data: data_q};

	// Line idles high.
	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
			rx_prev <= 1'b1;
		end else begin
			rx_meta <= uart_rx_port;
			rx_sync <= rx_meta;
			rx_prev <= rx_sync;
		end
	end

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			active   <= 1'b0;
			bit_idx  <= '0;
			baud_cnt <= '0;
			vld_q    <= 1'b0;
		end else begin
			vld_q <= 1'b0;
			if (!active) begin
				if (rx_prev && !rx_sync) begin
					active   <= 1'b1;
					bit_idx  <= '0;
					baud_cnt <= '0;
				end
			end else begin
				baud_cnt <= (baud_cnt == BAUD_LAST) ? '0 : baud_cnt + 1'b1;
				if (baud_cnt == BAUD_LAST)
					bit_idx <= bit_idx + 4'd1;
				if (baud_cnt == BAUD_MID) begin
					// A start bit gone high again was a glitch.
					if (bit_idx == '0 && rx_sync)
						active <= 1'b0;
					if (bit_idx == STOP_BIT) begin
						active <= 1'b0;
						vld_q  <= rx_sync;
					end
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (active && baud_cnt == BAUD_MID && bit_idx != '0 && bit_idx != STOP_BIT)
			shreg <= {rx_sync, shreg[7:1]};
		if (active && baud_cnt == BAUD_MID && bit_idx == STOP_BIT)
			data_q <= shreg;
	end

endmodule

`default_nettype wire

// File: frame_tx_ctrl.sv
// ---------------------------------------------------------------------------
// Frame producer. Turns an accepted request into "&&", the characters and
// "&&" in the FIFO, then waits for every byte to leave the line.
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "uart_frame_macros.svh"

module frame_tx_ctrl import uart_pkg::*, frame_pkg::*; (
	input  wire             sys_clk,
	input  wire             sys_rst_n,
	input  wire frame_str_t tx_string,
	input  wire frame_len_t tx_length,
	input  wire             tx_req,
	input  wire             full,
	input  wire             byte_sent,
	output logic            push,
	output uart_byte_t      push_data,
	output logic            tx_busy,
	output logic            tx_done
);

	localparam frame_len_t MAX_LEN = frame_len_t'(`UF_MAX_CHARS);

	tx_state_e  state;
	frame_str_t str_q;
	frame_len_t len_q;
	frame_len_t char_idx;
	frame_len_t sent_cnt;
	logic       dcnt;

	assign tx_busy   = (state != TX_IDLE);
	assign push      = (state == TX_OPEN || state == TX_BODY || state == TX_CLOSE) && !full;
	assign push_data = (state == TX_BODY) ? str_q[8*char_idx +: 8] : `UF_DELIM;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			state    <= TX_IDLE;
			len_q    <= '0;
			char_idx <= '0;
			sent_cnt <= '0;
			dcnt     <= 1'b0;
			tx_done  <= 1'b0;
		end else begin
			tx_done <= 1'b0;
			// Every byte of the frame comes back as one byte_sent.
			if (tx_busy && byte_sent)
				sent_cnt <= sent_cnt + 8'd1;
			case (state)
				TX_IDLE: if (tx_req) begin
					len_q    <= (tx_length > MAX_LEN) ? MAX_LEN : tx_length;
					char_idx <= '0;
					sent_cnt <= '0;
					dcnt     <= 1'b0;
					state    <= TX_OPEN;
				end
				TX_OPEN: if (push) begin
					dcnt <= !dcnt;
					if (dcnt)
						state <= (len_q == '0) ? TX_CLOSE : TX_BODY;
				end
				TX_BODY: if (push) begin
					char_idx <= char_idx + 8'd1;
					if (char_idx == len_q - 8'd1)
						state <= TX_CLOSE;
				end
				TX_CLOSE: if (push) begin
					dcnt <= !dcnt;
					if (dcnt)
						state <= TX_WAIT;
				end
				TX_WAIT: if (byte_sent && sent_cnt == len_q + 8'd3) begin
					tx_done <= 1'b1;
					state   <= TX_IDLE;
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (state == TX_IDLE && tx_req)
			str_q <= tx_string;
	end

endmodule

`default_nettype wire

// File: byte_fifo.sv
// ---------------------------------------------------------------------------
// Synchronous byte FIFO between the frame producer and the serializer.
// Push and pop may share a cycle; pop_data shows the oldest entry.
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "uart_frame_macros.svh"

module byte_fifo import uart_pkg::*, frame_pkg::*; (
	input  wire             sys_clk,
	input  wire             sys_rst_n,
	input  wire             push,
	input  wire uart_byte_t push_data,
	input  wire             pop,
	output uart_byte_t      pop_data,
	output logic            full,
	output logic            empty
);

	localparam int             DEPTH   = `UF_FIFO_DEPTH;
	localparam fifo_idx_t      PTR_MAX = fifo_idx_t'(DEPTH - 1);
	localparam int             CNT_W   = $clog2(DEPTH + 1);

	uart_byte_t       mem [DEPTH];
	fifo_idx_t        wr_ptr;
	fifo_idx_t        rd_ptr;
	logic [CNT_W-1:0] count;
	logic             do_push;
	logic             do_pop;

	assign do_push  = push && !full;
	assign do_pop   = pop && !empty;
	assign full     = (count == CNT_W'(DEPTH));
	assign empty    = (count == '0);
	assign pop_data = mem[rd_ptr];

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (do_push)
				wr_ptr <= (wr_ptr == PTR_MAX) ? '0 : wr_ptr + 1'b1;
			if (do_pop)
				rd_ptr <= (rd_ptr == PTR_MAX) ? '0 : rd_ptr + 1'b1;
			// Occupancy holds when both happen together.
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (do_push)
			mem[wr_ptr] <= push_data;
	end

endmodule

`default_nettype wire

// File: uart_tx.sv
// ---------------------------------------------------------------------------
// Serializer on the consumer side of the transmit FIFO. Pops one byte when
// idle and sends start, 8 data bits LSB first and stop on uart_tx_port.
// ---------------------------------------------------------------------------

`timescale 1ns/100ps
`default_nettype none

`include "uart_frame_macros.svh"

module uart_tx import uart_pkg::*; (
	input  wire             sys_clk,
	input  wire             sys_rst_n,
	input  wire             empty,
	input  wire uart_byte_t pop_data,
	output logic            pop,
	output logic            byte_sent,
	output logic            uart_tx_port
);

	localparam baud_cnt_t  BAUD_LAST = baud_cnt_t'(`UF_CLKS_PER_BIT - 1);
	localparam logic [3:0] STOP_BIT  = 4'd9;

	logic       busy;
	logic [3:0] bit_idx;
	baud_cnt_t  baud_cnt;
	// Data bits followed by the stop bit.
	logic [8:0] shreg;

	assign pop = !busy && !empty;

	always_ff @(posedge sys_clk or negedge sys_rst_n) begin
		if (!sys_rst_n) begin
			busy         <= 1'b0;
			bit_idx      <= '0;
			baud_cnt     <= '0;
			byte_sent    <= 1'b0;
			uart_tx_port <= 1'b1;
		end else begin
			byte_sent <= 1'b0;
			if (pop) begin
				// Start bit goes out from the next cycle.
				busy         <= 1'b1;
				bit_idx      <= '0;
				baud_cnt     <= '0;
				uart_tx_port <= 1'b0;
			end else if (busy) begin
				if (baud_cnt == BAUD_LAST) begin
					baud_cnt <= '0;
					if (bit_idx == STOP_BIT) begin
						busy      <= 1'b0;
						byte_sent <= 1'b1;
					end else begin
						bit_idx      <= bit_idx + 4'd1;
						uart_tx_port <= shreg[0];
					end
				end else begin
					baud_cnt <= baud_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge sys_clk) begin
		if (pop)
			shreg <= {1'b1, pop_data};
		else if (busy && baud_cnt == BAUD_LAST)
			shreg <= {1'b1, shreg[8:1]};
	end

endmodule

`default_nettype wire

// File: frame_pkg.sv
// ---------------------------------------------------------------------------
// Frame-level types for the string link: string, length, published receive
// result, FIFO index and the producer and parser state encodings.
// ---------------------------------------------------------------------------

`default_nettype none

`include "uart_frame_macros.svh"

package frame_pkg;

	// Character k sits in bits 8k+7 down to 8k.
	typedef logic [`UF_MAX_CHARS*8-1:0] frame_str_t;

	// Character count, 0 to 16 in use.
	typedef logic [7:0] frame_len_t;

	// Published receive result.
	typedef struct packed {
		frame_str_t str;
		frame_len_t len;
	} frame_result_t;

	// Read and write pointer of the transmit FIFO.
	typedef logic [$clog2(`UF_FIFO_DEPTH)-1:0] fifo_idx_t;

	// Producer FSM.
	typedef enum logic [2:0] {
		TX_IDLE,
		TX_OPEN,
		TX_BODY,
		TX_CLOSE,
		TX_WAIT
	} tx_state_e;

	// Parser FSM.
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_OPEN1,
		RX_BODY,
		RX_CLOSE1
	} rx_state_e;

endpackage

`default_nettype wire

// File: uart_pkg.sv
// ---------------------------------------------------------------------------
// Line-level types shared by the serializer, the deserializer and the
// transmit FIFO. Import where serial bytes or bit timing are handled.
// ---------------------------------------------------------------------------

`default_nettype none

`include "uart_frame_macros.svh"

package uart_pkg;

	// One byte as it travels on the serial line.
	typedef logic [7:0] uart_byte_t;

	// Clock count within one bit time.
	typedef logic [$clog2(`UF_CLKS_PER_BIT)-1:0] baud_cnt_t;

	// Received byte with its one-cycle valid strobe.
	typedef struct packed {
		logic       vld;
		uart_byte_t data;
	} rx_beat_t;

endpackage

`default_nettype wire

// File: uart_frame_macros.svh
// ---------------------------------------------------------------------------
// Fixed parameters of the UART string link. Include this header wherever
// the bit time, frame limits, FIFO depth or delimiter byte are needed.
// ---------------------------------------------------------------------------

`ifndef UART_FRAME_MACROS_SVH
`define UART_FRAME_MACROS_SVH

// Clocks per serial bit.
// Kept small so simulation stays short.
`define UF_CLKS_PER_BIT 16

// Maximum characters carried in one frame.
`define UF_MAX_CHARS 16

// Entries in the transmit byte FIFO.
`define UF_FIFO_DEPTH 8

// Frame delimiter byte, "&".
`define UF_DELIM 8'h26

`endif
